/* logic/udp_rx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field widths and protocol constants for the UDP receive path
// IPv4 headers are fixed at 20 bytes, options are not supported
// UART timing assumes a 125 MHz clock and 115200 baud
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_rx_pkg;

    localparam int BYTE_W      = 8;
    localparam int MAC_W       = 48;
    localparam int IP_ADDR_W   = 32;
    localparam int PORT_W      = 16;
    localparam int ETHERTYPE_W = 16;

    // header lengths in bytes and the counters that walk them
    localparam int ETH_HDR_LEN = 14;
    localparam int IP_HDR_LEN  = 20;
    localparam int UDP_HDR_LEN = 8;
    localparam int ETH_CNT_W   = $clog2(ETH_HDR_LEN);
    localparam int IP_CNT_W    = $clog2(IP_HDR_LEN);
    localparam int UDP_CNT_W   = $clog2(UDP_HDR_LEN);

    // byte positions inside the IPv4 header
    localparam int IP_PROTO_IDX = 9;
    localparam int IP_SRC_LAST  = 15;

    localparam logic [ETHERTYPE_W-1:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [BYTE_W-1:0]      IP_PROTO_UDP   = 8'd17;
    localparam logic [3:0]             IP_VERSION_4   = 4'd4;
    localparam logic [3:0]             IP_IHL_MIN     = 4'd5;
    localparam logic [MAC_W-1:0]       MATCH_MAC      = 48'h2020_0000_00aa;

    // parse stage states
    localparam int              ST_W    = 2;
    localparam logic [ST_W-1:0] ST_HDR  = 2'd0;
    localparam logic [ST_W-1:0] ST_PASS = 2'd1;
    localparam logic [ST_W-1:0] ST_DROP = 2'd2;

    localparam int UART_CLKS_PER_BIT = 1085;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
    localparam int UART_BITS         = BYTE_W + 2;
    localparam int UART_IDX_W        = $clog2(UART_BITS);

endpackage

/* logic/byte_stream_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte wide stream, AXI stream style handshake
// tuser is only meaningful together with tlast (bad frame)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface byte_stream_if import udp_rx_pkg::*; ();

    logic [BYTE_W-1:0] tdata;
    logic              tvalid;
    logic              tready;
    logic              tlast;
    logic              tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* logic/eth_hdr_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strips the 14 byte Ethernet header, passes IPv4 frames only
// a frame ending on or before its last header byte is dropped
// src_mac and src_mac_match change only on accepted IPv4 headers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module eth_hdr_rx import udp_rx_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    byte_stream_if.sink      s,
    byte_stream_if.source    m,
    output logic [MAC_W-1:0] src_mac,
    output logic             src_mac_match
);

    logic [ST_W-1:0]         state;
    logic [ETH_CNT_W-1:0]    cnt;
    // holds header bytes 6..12 once the last byte is on the bus
    logic [MAC_W+BYTE_W-1:0] hdr_sr;
    logic [MAC_W-1:0]        hdr_mac;
    logic [ETHERTYPE_W-1:0]  hdr_type;
    logic                    hdr_done;
    logic                    is_ipv4;

    assign hdr_mac  = hdr_sr[MAC_W+BYTE_W-1:BYTE_W];
    assign hdr_type = {hdr_sr[BYTE_W-1:0], s.tdata};
    assign is_ipv4  = (hdr_type == ETHERTYPE_IPV4);
    assign hdr_done = (state == ST_HDR) && s.tvalid && !s.tlast &&
                      (cnt == ETH_CNT_W'(ETH_HDR_LEN - 1));

    // header and drop phases sink everything, payload is a straight link
    assign s.tready = (state == ST_PASS) ? m.tready : 1'b1;
    assign m.tvalid = (state == ST_PASS) && s.tvalid;
    assign m.tdata  = s.tdata;
    assign m.tlast  = s.tlast;
    assign m.tuser  = s.tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_HDR;
            cnt           <= '0;
            src_mac_match <= 1'b0;
        end else if (s.tvalid && s.tready) begin
            if (state == ST_HDR) begin
                cnt <= cnt + 1'b1;
                if (s.tlast) begin
                    // runt frame
                    cnt <= '0;
                end else if (hdr_done) begin
                    cnt   <= '0;
                    state <= is_ipv4 ? ST_PASS : ST_DROP;
                    if (is_ipv4) begin
                        src_mac_match <= (hdr_mac == MATCH_MAC);
                    end
                end
            end else if (s.tlast) begin
                state <= ST_HDR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_HDR && s.tvalid) begin
            hdr_sr <= {hdr_sr[MAC_W-1:0], s.tdata};
        end
        if (hdr_done && is_ipv4) begin
            src_mac <= hdr_mac;
        end
    end

endmodule

/* logic/ip_hdr_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strips a 20 byte IPv4 header, passes version 4, IHL 5, UDP
// no checksum check, any IHL other than 5 drops the frame
// a frame ending on or before its last header byte is dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ip_hdr_rx import udp_rx_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    byte_stream_if.sink          s,
    byte_stream_if.source        m,
    output logic [IP_ADDR_W-1:0] src_ip
);

    logic [ST_W-1:0]      state;
    logic [IP_CNT_W-1:0]  cnt;
    logic                 hdr_ok;
    logic [IP_ADDR_W-1:0] ip_sr;
    logic                 hdr_beat;
    logic                 hdr_done;

    assign hdr_beat = (state == ST_HDR) && s.tvalid;
    assign hdr_done = hdr_beat && !s.tlast && (cnt == IP_CNT_W'(IP_HDR_LEN - 1));

    assign s.tready = (state == ST_PASS) ? m.tready : 1'b1;
    assign m.tvalid = (state == ST_PASS) && s.tvalid;
    assign m.tdata  = s.tdata;
    assign m.tlast  = s.tlast;
    assign m.tuser  = s.tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_HDR;
            cnt    <= '0;
            hdr_ok <= 1'b0;
        end else if (s.tvalid && s.tready) begin
            if (state == ST_HDR) begin
                cnt <= cnt + 1'b1;
                // version and IHL share the first byte
                if (cnt == '0) begin
                    hdr_ok <= (s.tdata == {IP_VERSION_4, IP_IHL_MIN});
                end
                if (cnt == IP_CNT_W'(IP_PROTO_IDX) && s.tdata != IP_PROTO_UDP) begin
                    hdr_ok <= 1'b0;
                end
                if (s.tlast) begin
                    cnt <= '0;
                end else if (hdr_done) begin
                    cnt   <= '0;
                    state <= hdr_ok ? ST_PASS : ST_DROP;
                end
            end else if (s.tlast) begin
                state <= ST_HDR;
            end
        end
    end

    // source address sits in bytes 12..15, shifting stops after it
    always_ff @(posedge clk) begin
        if (hdr_beat && cnt <= IP_CNT_W'(IP_SRC_LAST)) begin
            ip_sr <= {ip_sr[IP_ADDR_W-BYTE_W-1:0], s.tdata};
        end
        if (hdr_done && hdr_ok) begin
            src_ip <= ip_sr;
        end
    end

endmodule

/* logic/udp_hdr_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strips the 8 byte UDP header and forwards the payload
// a frame ending on its header (no payload) gives no strobe
// header fields hold until the next complete UDP header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_hdr_rx import udp_rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    byte_stream_if.sink       s,
    output logic [BYTE_W-1:0] payload_tdata,
    output logic              payload_tvalid,
    input  logic              payload_tready,
    output logic              payload_tlast,
    output logic              payload_tuser,
    output logic [PORT_W-1:0] src_port,
    output logic [PORT_W-1:0] dst_port,
    output logic [PORT_W-1:0] udp_length,
    output logic              udp_hdr_valid
);

    logic                         in_hdr;
    logic [UDP_CNT_W-1:0]         cnt;
    // ports, length and checksum high byte before the final byte
    logic [3*PORT_W+BYTE_W-1:0]   hdr_sr;
    logic                         hdr_done;

    assign hdr_done = in_hdr && s.tvalid && !s.tlast &&
                      (cnt == UDP_CNT_W'(UDP_HDR_LEN - 1));

    assign s.tready       = in_hdr ? 1'b1 : payload_tready;
    assign payload_tvalid = !in_hdr && s.tvalid;
    assign payload_tdata  = s.tdata;
    assign payload_tlast  = s.tlast;
    assign payload_tuser  = s.tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_hdr        <= 1'b1;
            cnt           <= '0;
            udp_hdr_valid <= 1'b0;
        end else begin
            udp_hdr_valid <= hdr_done;
            if (s.tvalid && s.tready) begin
                if (in_hdr) begin
                    cnt <= (s.tlast || hdr_done) ? '0 : cnt + 1'b1;
                    if (hdr_done) begin
                        in_hdr <= 1'b0;
                    end
                end else if (s.tlast) begin
                    in_hdr <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_hdr && s.tvalid) begin
            hdr_sr <= {hdr_sr[3*PORT_W-1:0], s.tdata};
        end
        if (hdr_done) begin
            src_port   <= hdr_sr[BYTE_W+3*PORT_W-1 -: PORT_W];
            dst_port   <= hdr_sr[BYTE_W+2*PORT_W-1 -: PORT_W];
            udp_length <= hdr_sr[BYTE_W+PORT_W-1 -: PORT_W];
        end
    end

endmodule

/* logic/uart_byte_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 transmitter, one byte per start pulse, LSB first
// start pulses while a byte is in flight are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_byte_tx import udp_rx_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [BYTE_W-1:0] data,
    output logic              tx
);

    logic                  busy;
    logic [UART_CNT_W-1:0] baud_cnt;
    logic [UART_IDX_W-1:0] bit_idx;
    // stop, data, start; bit 0 is on the line
    logic [UART_BITS-1:0]  frame;

    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            frame    <= '1;
        end else if (!busy) begin
            if (start) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
                frame    <= {1'b1, data, 1'b0};
            end
        end else if (baud_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[UART_BITS-1:1]};
            // idle again once the stop bit has run its full period
            if (bit_idx == UART_IDX_W'(UART_BITS - 1)) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

/* logic/fpga_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive path Ethernet -> IPv4 -> UDP, single clock domain
// uart_tx carries the low source MAC byte of each UDP frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpga_core import udp_rx_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [BYTE_W-1:0]    rx_tdata,
    input  logic                 rx_tvalid,
    output logic                 rx_tready,
    input  logic                 rx_tlast,
    input  logic                 rx_tuser,
    output logic [BYTE_W-1:0]    payload_tdata,
    output logic                 payload_tvalid,
    input  logic                 payload_tready,
    output logic                 payload_tlast,
    output logic                 payload_tuser,
    output logic                 udp_hdr_valid,
    output logic [MAC_W-1:0]     src_mac,
    output logic [IP_ADDR_W-1:0] src_ip,
    output logic [PORT_W-1:0]    src_port,
    output logic [PORT_W-1:0]    dst_port,
    output logic [PORT_W-1:0]    udp_length,
    output logic                 src_mac_match,
    output logic                 uart_tx
);

    byte_stream_if rx_bs ();
    byte_stream_if eth_bs ();
    byte_stream_if ip_bs ();

    assign rx_bs.tdata  = rx_tdata;
    assign rx_bs.tvalid = rx_tvalid;
    assign rx_bs.tlast  = rx_tlast;
    assign rx_bs.tuser  = rx_tuser;
    assign rx_tready    = rx_bs.tready;

    eth_hdr_rx eth_hdr_rx_inst (
        .clk(clk),
        .rst(rst),
        .s(rx_bs),
        .m(eth_bs),
        .src_mac(src_mac),
        .src_mac_match(src_mac_match)
    );

    ip_hdr_rx ip_hdr_rx_inst (
        .clk(clk),
        .rst(rst),
        .s(eth_bs),
        .m(ip_bs),
        .src_ip(src_ip)
    );

    udp_hdr_rx udp_hdr_rx_inst (
        .clk(clk),
        .rst(rst),
        .s(ip_bs),
        .payload_tdata(payload_tdata),
        .payload_tvalid(payload_tvalid),
        .payload_tready(payload_tready),
        .payload_tlast(payload_tlast),
        .payload_tuser(payload_tuser),
        .src_port(src_port),
        .dst_port(dst_port),
        .udp_length(udp_length),
        .udp_hdr_valid(udp_hdr_valid)
    );

    // src_mac is already stable when the UDP strobe fires
    uart_byte_tx uart_byte_tx_inst (
        .clk(clk),
        .rst(rst),
        .start(udp_hdr_valid),
        .data(src_mac[BYTE_W-1:0]),
        .tx(uart_tx)
    );

endmodule

/* tests/fpga_core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random Ethernet/IPv4/UDP frames against a queue based model
// frames ending on or before the last UDP header byte are dropped
// UART bytes are decoded only for the final group of frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpga_core_tb import udp_rx_pkg::*; ();

    localparam int N_RAND      = 56;
    localparam int N_UART      = 4;
    localparam int MAX_PAYLOAD = 20;
    localparam int HDRS_LEN    = ETH_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN;
    localparam int HDR_W       = MAC_W + IP_ADDR_W + 3 * PORT_W;
    localparam int BYTE_TIME   = UART_BITS * UART_CLKS_PER_BIT;
    // up to 4 cycles per byte, two UART byte times per UART frame
    localparam int CYCLE_LIMIT = (N_RAND + N_UART) * (HDRS_LEN + MAX_PAYLOAD) * 4 +
                                 (2 * N_UART + 1) * BYTE_TIME + 2000;

    logic clk;
    logic rst;
    logic [BYTE_W-1:0] rx_tdata;
    logic rx_tvalid;
    logic rx_tready;
    logic rx_tlast;
    logic rx_tuser;
    logic [BYTE_W-1:0] payload_tdata;
    logic payload_tvalid;
    logic payload_tready;
    logic payload_tlast;
    logic payload_tuser;
    logic udp_hdr_valid;
    logic [MAC_W-1:0] src_mac;
    logic [IP_ADDR_W-1:0] src_ip;
    logic [PORT_W-1:0] src_port;
    logic [PORT_W-1:0] dst_port;
    logic [PORT_W-1:0] udp_length;
    logic src_mac_match;
    logic uart_tx;

    integer seed;
    integer bp_seed;
    int cycles = 0;
    int hdr_cnt = 0;
    int byte_cnt = 0;
    logic last_user;
    logic [BYTE_W-1:0] fb[$];
    // {mac, ip, src port, dst port, length} and {tuser, tlast, tdata}
    logic [HDR_W-1:0] exp_hdr[$];
    logic [BYTE_W+1:0] exp_pl[$];

    fpga_core dut_i (.*);

    always #4 clk = ~clk;

    // back-pressure on its own random stream
    always @(negedge clk) begin
        payload_tready = ({$random(bp_seed)} % 4) != 0;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_hdr_field(input string name, input logic [MAC_W-1:0] exp,
                                   input logic [MAC_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                              input logic [BYTE_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            fail_run("timeout: the DUT did not finish the frames within the cycle limit");
        end
    end

    // header strobe and payload monitor
    always @(posedge clk) begin
        logic [HDR_W-1:0] h;
        logic [BYTE_W+1:0] p;
        if (!rst && udp_hdr_valid) begin
            if (exp_hdr.size() == 0) begin
                fail_run("a UDP header strobe came for a frame that should be dropped");
            end else begin
                h = exp_hdr.pop_front();
                check_hdr_field($sformatf("hdr %0d src_mac", hdr_cnt),
                                h[HDR_W-1 -: MAC_W], src_mac);
                check_hdr_field($sformatf("hdr %0d src_ip", hdr_cnt),
                                MAC_W'(h[3*PORT_W+IP_ADDR_W-1 -: IP_ADDR_W]), MAC_W'(src_ip));
                check_hdr_field($sformatf("hdr %0d src_port", hdr_cnt),
                                MAC_W'(h[3*PORT_W-1 -: PORT_W]), MAC_W'(src_port));
                check_hdr_field($sformatf("hdr %0d dst_port", hdr_cnt),
                                MAC_W'(h[2*PORT_W-1 -: PORT_W]), MAC_W'(dst_port));
                check_hdr_field($sformatf("hdr %0d udp_length", hdr_cnt),
                                MAC_W'(h[PORT_W-1:0]), MAC_W'(udp_length));
                check_flag($sformatf("hdr %0d src_mac_match", hdr_cnt),
                           h[HDR_W-1 -: MAC_W] == MATCH_MAC, src_mac_match);
                hdr_cnt = hdr_cnt + 1;
            end
        end
        if (!rst && payload_tvalid && payload_tready) begin
            if (exp_pl.size() == 0) begin
                fail_run("a payload byte came out that no accepted frame carries");
            end else begin
                p = exp_pl.pop_front();
                check_byte($sformatf("payload %0d tdata", byte_cnt),
                           p[BYTE_W-1:0], payload_tdata);
                check_flag($sformatf("payload %0d tlast", byte_cnt), p[BYTE_W], payload_tlast);
                check_flag($sformatf("payload %0d tuser", byte_cnt), p[BYTE_W+1], payload_tuser);
                byte_cnt = byte_cnt + 1;
            end
        end
    end

    // low nbytes of v, most significant first
    task automatic push_field(input logic [MAC_W-1:0] v, input int nbytes);
        for (int k = nbytes - 1; k >= 0; k--) begin
            fb.push_back(8'(v >> (k * BYTE_W)));
        end
    endtask

    task automatic build_frame(input logic force_ok);
        logic [MAC_W-1:0] mac;
        logic [IP_ADDR_W-1:0] ip;
        logic [PORT_W-1:0] sport;
        logic [PORT_W-1:0] dport;
        logic [PORT_W-1:0] ulen;
        logic [ETHERTYPE_W-1:0] etype;
        logic [BYTE_W-1:0] ver_ihl;
        logic [BYTE_W-1:0] proto;
        int kind;
        int plen;
        int flen;
        // 0 bad ethertype, 1 bad version/IHL, 2 TCP, 3 truncated, else good
        kind = force_ok ? 7 : {$random(seed)} % 8;
        mac = ({$random(seed)} % 3 == 0) ? MATCH_MAC : {16'($random(seed)), 32'($random(seed))};
        ip = 32'($random(seed));
        sport = 16'($random(seed));
        dport = 16'($random(seed));
        ulen = 16'($random(seed));
        etype = ETHERTYPE_IPV4;
        ver_ihl = {IP_VERSION_4, IP_IHL_MIN};
        proto = IP_PROTO_UDP;
        if (kind == 0) begin
            etype = 16'($random(seed));
            if (etype == ETHERTYPE_IPV4) etype = 16'h86dd;
        end
        if (kind == 1) begin
            ver_ihl = 8'($random(seed));
            if (ver_ihl == {IP_VERSION_4, IP_IHL_MIN}) ver_ihl = 8'h46;
        end
        if (kind == 2) proto = 8'd6;
        plen = force_ok ? 1 + {$random(seed)} % MAX_PAYLOAD : {$random(seed)} % (MAX_PAYLOAD + 1);
        fb.delete();
        push_field({16'($random(seed)), 32'($random(seed))}, 6);
        push_field(mac, 6);
        push_field(MAC_W'(etype), 2);
        fb.push_back(ver_ihl);
        repeat (8) fb.push_back(8'($random(seed)));
        fb.push_back(proto);
        repeat (2) fb.push_back(8'($random(seed)));
        push_field(MAC_W'(ip), 4);
        repeat (4) fb.push_back(8'($random(seed)));
        push_field(MAC_W'(sport), 2);
        push_field(MAC_W'(dport), 2);
        push_field(MAC_W'(ulen), 2);
        repeat (2 + plen) fb.push_back(8'($random(seed)));
        flen = HDRS_LEN + plen;
        if (kind == 3) flen = 1 + {$random(seed)} % HDRS_LEN;
        while (fb.size() > flen) fb.delete(fb.size() - 1);
        last_user = 1'($random(seed));
        // a frame needs all three headers and at least one payload byte
        if (kind >= 3 && flen > HDRS_LEN) begin
            exp_hdr.push_back({mac, ip, sport, dport, ulen});
            for (int i = HDRS_LEN; i < flen; i++) begin
                exp_pl.push_back({(i == flen - 1) && last_user, i == flen - 1, fb[i]});
            end
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < fb.size(); i++) begin
            if (({$random(seed)} % 4) == 0) begin
                rx_tvalid = 1'b0;
                @(negedge clk);
            end
            rx_tdata = fb[i];
            rx_tvalid = 1'b1;
            rx_tlast = (i == fb.size() - 1);
            rx_tuser = rx_tlast && last_user;
            @(posedge clk);
            while (!rx_tready) @(posedge clk);
            @(negedge clk);
        end
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr.size() != 0 || exp_pl.size() != 0) @(posedge clk);
    endtask

    // a full byte time of high line means no byte is in flight
    task automatic wait_uart_idle();
        int hi;
        hi = 0;
        while (hi < BYTE_TIME) begin
            @(posedge clk);
            hi = uart_tx ? hi + 1 : 0;
        end
    endtask

    task automatic decode_uart(input logic [BYTE_W-1:0] exp_byte);
        logic [BYTE_W-1:0] got;
        got = '0;
        while (uart_tx) @(posedge clk);
        repeat (UART_CLKS_PER_BIT / 2) @(posedge clk);
        check_flag("uart start bit", 1'b0, uart_tx);
        repeat (BYTE_W) begin
            repeat (UART_CLKS_PER_BIT) @(posedge clk);
            got = {uart_tx, got[BYTE_W-1:1]};
        end
        repeat (UART_CLKS_PER_BIT) @(posedge clk);
        check_flag("uart stop bit", 1'b1, uart_tx);
        check_byte("uart data", exp_byte, got);
    endtask

    initial begin
        seed = 32'h5cd49294;
        bp_seed = seed + 1;
        clk = 1'b0;
        rst = 1'b1;
        rx_tdata = '0;
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
        payload_tready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < N_RAND; f++) begin
            build_frame(1'b0);
            send_frame();
        end
        wait_drain();
        for (int f = 0; f < N_UART; f++) begin
            wait_uart_idle();
            @(negedge clk);
            build_frame(1'b1);
            // byte 11 is the low byte of the source MAC
            fork
                send_frame();
                decode_uart(fb[11]);
            join
        end
        wait_drain();
        $display("Test passed");
        $finish;
    end

endmodule

/* filelist.f */
logic/udp_rx_pkg.sv
logic/byte_stream_if.sv
logic/eth_hdr_rx.sv
logic/ip_hdr_rx.sv
logic/udp_hdr_rx.sv
logic/uart_byte_tx.sv
logic/fpga_core.sv
tests/fpga_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := fpga_core_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
